// ==== design/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// data path and address width
`define XLEN 64

// instruction word width
`define INS_W 32

// architectural register index
`define REG_IDX_W 5

// operation code width
`define ALU_OP_W 5

// branch offset bits 12:1
`define BIMM_W 12

`endif

// ==== design/ex_pkg.sv ====
`include "ex_defs.svh"

package ex_pkg;

	typedef logic [`XLEN-1:0] word_t;

	// numbering is fixed, the decode stage depends on it
	typedef enum logic [`ALU_OP_W-1:0] {
		op_add,    // 0
		op_addw,
		op_sll,
		op_sllw,
		op_sra,
		op_sraw,   // 5
		op_srl,
		op_srlw,
		op_and,
		op_or,
		op_xor,    // 10
		op_slt,
		op_sltu,
		op_seq,
		op_sne,
		op_sge,    // 15
		op_sgeu,
		op_sub,
		op_subw,
		op_mul,    // low 64 bits
		op_mulh,   // 20
		op_mulhu,
		op_mulw,
		op_div,
		op_divu,
		op_divw,   // 25
		op_divuw,
		op_rem,
		op_remu,
		op_remuw,
		op_remw    // 30
	} alu_op_e;

	typedef enum logic [1:0] {
		size_b,
		size_h,
		size_w,
		size_d
	} mem_size_e;

endpackage

// ==== design/int_alu.sv ====
`include "ex_defs.svh"

module int_alu import ex_pkg::*; (
	input  alu_op_e op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result
);

	logic [5:0]  shamt;
	logic [4:0]  shamt_w;
	word_t       sum;
	word_t       diff;
	logic [31:0] add_w;
	logic [31:0] sub_w;
	logic [31:0] sll_w;
	logic [31:0] srl_w;
	logic [31:0] sra_w;

	assign shamt   = b[5:0];
	assign shamt_w = b[4:0];   // word shifts ignore bit 5

	assign sum  = a + b;
	assign diff = a - b;

	assign add_w = a[31:0] + b[31:0];
	assign sub_w = a[31:0] - b[31:0];
	assign sll_w = a[31:0] << shamt_w;
	assign srl_w = a[31:0] >> shamt_w;
	assign sra_w = $signed(a[31:0]) >>> shamt_w;

	always_comb begin
		case (op)
			op_add:
				result = sum;
			op_addw:
				result = {{32{add_w[31]}}, add_w};
			op_sll:
				result = a << shamt;
			op_sllw:
				result = {{32{sll_w[31]}}, sll_w};
			op_sra:
				result = $signed(a) >>> shamt;
			op_sraw:
				result = {{32{sra_w[31]}}, sra_w};
			op_srl:
				result = a >> shamt;
			op_srlw:
				result = {{32{srl_w[31]}}, srl_w};   // bit 31 set only when shamt_w is 0
			op_and:
				result = a & b;
			op_or:
				result = a | b;
			op_xor:
				result = a ^ b;
			op_slt:
				result = word_t'($signed(a) < $signed(b));
			op_sltu:
				result = word_t'(a < b);
			op_seq:
				result = word_t'(a == b);
			op_sne:
				result = word_t'(a != b);
			op_sge:
				result = word_t'($signed(a) >= $signed(b));
			op_sgeu:
				result = word_t'(a >= b);
			op_sub:
				result = diff;
			op_subw:
				result = {{32{sub_w[31]}}, sub_w};
			default:
				result = '0;   // mul/div results come from the iterative units
		endcase
	end

endmodule

// ==== design/mul_unit.sv ====
`include "ex_defs.svh"

module mul_unit import ex_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  start,
	input  logic  ack,
	input  logic  mul_signed,
	input  logic  mul_word,
	input  word_t a,
	input  word_t b,
	output logic  done,
	output logic  busy,
	output word_t prod_hi,
	output word_t prod_lo
);

	localparam int CNT_W = $clog2(`XLEN);

	logic [CNT_W-1:0]    cnt;
	logic                fix;
	logic                neg_q;
	logic                word_q;
	word_t               mcand;
	word_t               hi;
	word_t               lo;
	word_t               mag_a;
	word_t               mag_b;
	word_t               src_hi;
	word_t               src_lo;
	word_t               src_mc;
	logic [`XLEN:0]      partial;
	logic [2*`XLEN-1:0]  step;
	logic [2*`XLEN-1:0]  fixed;

	assign mag_a = (mul_signed && a[`XLEN-1]) ? -a : a;
	assign mag_b = (mul_signed && b[`XLEN-1]) ? -b : b;

	// first add-shift step runs in the start cycle
	assign src_hi = start ? '0 : hi;
	assign src_lo = start ? mag_b : lo;
	assign src_mc = start ? mag_a : mcand;

	assign partial = {1'b0, src_hi} + (src_lo[0] ? {1'b0, src_mc} : '0);
	assign step    = {partial, src_lo[`XLEN-1:1]};

	assign fixed = neg_q ? -{hi, lo} : {hi, lo};

	assign prod_hi = hi;
	assign prod_lo = lo;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			fix  <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			if (ack)
				done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= CNT_W'(1);
			end else if (fix) begin
				fix  <= 1'b0;
				busy <= 1'b0;
				done <= 1'b1;   // held until ack
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_W'(`XLEN - 1))
					fix <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand    <= mag_a;
			neg_q    <= mul_signed & (a[`XLEN-1] ^ b[`XLEN-1]);
			word_q   <= mul_word;
			{hi, lo} <= step;
		end else if (fix) begin
			hi <= fixed[2*`XLEN-1:`XLEN];
			lo <= word_q ? {{32{fixed[31]}}, fixed[31:0]} : fixed[`XLEN-1:0];
		end else if (busy) begin
			{hi, lo} <= step;
		end
	end

	// ex_stage must wait for done before issuing again
	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy);

endmodule

// ==== design/div_unit.sv ====
`include "ex_defs.svh"

module div_unit import ex_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  start,
	input  logic  ack,
	input  logic  div_signed,
	input  logic  div_word,
	input  word_t dividend,
	input  word_t divisor,
	output logic  done,
	output logic  busy,
	output word_t quot,
	output word_t rem
);

	localparam int CNT_W = $clog2(`XLEN);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] last;
	logic             fix;
	logic             neg_q;
	logic             rneg_q;
	logic             word_q;
	word_t            q_reg;
	word_t            r_reg;
	word_t            d_reg;
	word_t            op_a;
	word_t            op_b;
	logic             sign_a;
	logic             sign_b;
	logic             div_zero;
	word_t            mag_a;
	word_t            mag_b;
	logic [`XLEN:0]   shifted;
	logic [`XLEN:0]   diff;
	logic             ge;
	word_t            q_fix;
	word_t            r_fix;

	// word forms divide the low halves, extended by signedness
	always_comb begin
		if (div_word) begin
			op_a = div_signed ? {{32{dividend[31]}}, dividend[31:0]} : {32'b0, dividend[31:0]};
			op_b = div_signed ? {{32{divisor[31]}}, divisor[31:0]} : {32'b0, divisor[31:0]};
		end else begin
			op_a = dividend;
			op_b = divisor;
		end
	end

	assign sign_a   = div_signed & op_a[`XLEN-1];
	assign sign_b   = div_signed & op_b[`XLEN-1];
	assign div_zero = (op_b == '0);
	assign mag_a    = sign_a ? -op_a : op_a;
	assign mag_b    = sign_b ? -op_b : op_b;

	// restoring step
	assign shifted = {r_reg, q_reg[`XLEN-1]};
	assign diff    = shifted - {1'b0, d_reg};
	assign ge      = !diff[`XLEN];

	assign last = word_q ? CNT_W'(31) : CNT_W'(`XLEN - 1);

	// overflow (min / -1) falls out of the magnitude path as quotient = dividend
	assign q_fix = neg_q ? -q_reg : q_reg;
	assign r_fix = rneg_q ? -r_reg : r_reg;

	assign quot = q_reg;
	assign rem  = r_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			fix  <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			if (ack)
				done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				fix  <= div_zero;   // nothing to iterate
				cnt  <= '0;
			end else if (fix) begin
				fix  <= 1'b0;
				busy <= 1'b0;
				done <= 1'b1;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == last)
					fix <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			word_q <= div_word;
			d_reg  <= mag_b;
			if (div_zero) begin
				q_reg  <= '1;
				r_reg  <= op_a;
				neg_q  <= 1'b0;
				rneg_q <= 1'b0;
			end else begin
				q_reg  <= div_word ? {mag_a[31:0], 32'b0} : mag_a;
				r_reg  <= '0;
				neg_q  <= sign_a ^ sign_b;
				rneg_q <= sign_a;   // remainder follows the dividend
			end
		end else if (fix) begin
			q_reg <= word_q ? {{32{q_fix[31]}}, q_fix[31:0]} : q_fix;
			r_reg <= word_q ? {{32{r_fix[31]}}, r_fix[31:0]} : r_fix;
		end else if (busy) begin
			q_reg <= {q_reg[`XLEN-2:0], ge};
			r_reg <= ge ? diff[`XLEN-1:0] : shifted[`XLEN-1:0];
		end
	end

	a_done_idle: assert property (@(posedge clk) disable iff (reset)
		done |-> !busy);

endmodule

// ==== design/ex_stage.sv ====
`include "ex_defs.svh"

module ex_stage import ex_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  word_t                 pc,
	input  logic [`INS_W-1:0]     ins,
	input  alu_op_e               alu_op,
	input  word_t                 src_a,
	input  word_t                 src_b,
	input  word_t                 rs2_data,
	input  logic [`REG_IDX_W-1:0] rd,
	input  logic                  reg_write,
	input  logic                  mem_write,
	input  logic                  mem_read,
	input  logic                  branch,
	input  logic [`BIMM_W-1:0]    bimm,
	input  logic                  next_ready,
	input  logic                  mem_aw_ready,
	input  logic                  mem_ar_ready,
	output logic                  ready_out,
	output logic                  valid_out,
	output word_t                 out_pc,
	output logic [`INS_W-1:0]     out_ins,
	output word_t                 out_result,
	output word_t                 out_rs2_data,
	output logic [`REG_IDX_W-1:0] out_rd,
	output logic                  out_reg_write,
	output logic                  out_mem_write,
	output logic                  out_mem_read,
	output logic                  flush,
	output word_t                 branch_target,
	output logic                  mem_aw_valid,
	output logic                  mem_ar_valid,
	output word_t                 mem_addr,
	output mem_size_e             mem_size,
	output word_t                 mem_w_data
);

	word_t alu_res;
	word_t ex_result;
	word_t prod_hi;
	word_t prod_lo;
	word_t quot;
	word_t rem;
	logic  is_mul;
	logic  is_div;
	logic  mul_signed;
	logic  mul_word;
	logic  div_signed;
	logic  div_word;
	logic  mul_start;
	logic  mul_done;
	logic  mul_busy;
	logic  div_start;
	logic  div_done;
	logic  div_busy;
	logic  unit_ok;
	logic  mem_ok;
	logic  xfer;
	logic  branch_taken;

	int_alu int_alu_i (
		.op     (alu_op),
		.a      (src_a),
		.b      (src_b),
		.result (alu_res)
	);

	mul_unit mul_unit_i (
		.clk        (clk),
		.reset      (reset),
		.start      (mul_start),
		.ack        (xfer),
		.mul_signed (mul_signed),
		.mul_word   (mul_word),
		.a          (src_a),
		.b          (src_b),
		.done       (mul_done),
		.busy       (mul_busy),
		.prod_hi    (prod_hi),
		.prod_lo    (prod_lo)
	);

	div_unit div_unit_i (
		.clk        (clk),
		.reset      (reset),
		.start      (div_start),
		.ack        (xfer),
		.div_signed (div_signed),
		.div_word   (div_word),
		.dividend   (src_a),
		.divisor    (src_b),
		.done       (div_done),
		.busy       (div_busy),
		.quot       (quot),
		.rem        (rem)
	);

	assign is_mul = alu_op inside {[op_mul:op_mulw]};
	assign is_div = alu_op inside {[op_div:op_remw]};

	assign mul_signed = (alu_op == op_mulh) || (alu_op == op_mulw);
	assign mul_word   = (alu_op == op_mulw);
	assign div_signed = alu_op inside {op_div, op_divw, op_rem, op_remw};
	assign div_word   = alu_op inside {op_divw, op_divuw, op_remuw, op_remw};

	// one-cycle start, unit idle and no result pending
	assign mul_start = valid_in && is_mul && !mul_busy && !mul_done;
	assign div_start = valid_in && is_div && !div_busy && !div_done;

	always_comb begin
		case (alu_op)
			op_mul, op_mulw:                    ex_result = prod_lo;   // mulw already sign-extended
			op_mulh, op_mulhu:                  ex_result = prod_hi;
			op_div, op_divu, op_divw, op_divuw: ex_result = quot;
			op_rem, op_remu, op_remuw, op_remw: ex_result = rem;
			default:                            ex_result = alu_res;
		endcase
	end

	assign unit_ok   = (!is_mul || mul_done) && (!is_div || div_done);
	assign mem_ok    = (!mem_write || mem_aw_ready) && (!mem_read || mem_ar_ready);
	assign ready_out = next_ready && mem_ok && unit_ok;
	assign xfer      = valid_in && ready_out;

	assign branch_taken  = branch && (alu_res != '0);
	assign flush         = branch_taken && xfer;
	assign branch_target = pc + {{(`XLEN - `BIMM_W - 1){bimm[`BIMM_W-1]}}, bimm, 1'b0};

	assign mem_aw_valid = valid_in && mem_write;
	assign mem_ar_valid = valid_in && mem_read;
	assign mem_addr     = src_a + src_b;   // ALU sum
	assign mem_w_data   = rs2_data;
	assign mem_size     = mem_write ? mem_size_e'(ins[13:12]) : size_d;   // funct3[1:0]

	always_ff @(posedge clk) begin
		if (reset)
			valid_out <= 1'b0;
		else if (xfer)
			valid_out <= 1'b1;
		else if (next_ready)
			valid_out <= 1'b0;   // bubble while stalled
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			out_pc        <= pc;
			out_ins       <= ins;
			out_result    <= ex_result;
			out_rs2_data  <= rs2_data;
			out_rd        <= rd;
			out_reg_write <= reg_write;
			out_mem_write <= mem_write;
			out_mem_read  <= mem_read;
		end
	end

	a_one_mem_req: assert property (@(posedge clk) disable iff (reset)
		!(mem_aw_valid && mem_ar_valid));

endmodule

// ==== dv/ex_tb_model.svh ====
`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

function automatic word_t sext_w(input logic [31:0] v);
	return {{32{v[31]}}, v};
endfunction

// word forms divide the extended low halves and keep 32 result bits
function automatic word_t div_model(input logic sgn, input logic word_form, input logic want_rem,
		input word_t a, input word_t b);
	word_t x;
	word_t y;
	word_t q;
	word_t r;
	x = a;
	y = b;
	if (word_form) begin
		x = sgn ? sext_w(a[31:0]) : {32'd0, a[31:0]};
		y = sgn ? sext_w(b[31:0]) : {32'd0, b[31:0]};
	end
	if (y == '0) begin
		q = '1;
		r = x;
	end else if (sgn && x == {1'b1, 63'd0} && y == '1) begin
		q = x;   // signed overflow
		r = '0;
	end else if (sgn) begin
		q = $signed(x) / $signed(y);
		r = $signed(x) % $signed(y);
	end else begin
		q = x / y;
		r = x % y;
	end
	if (word_form) begin
		q = sext_w(q[31:0]);
		r = sext_w(r[31:0]);
	end
	return want_rem ? r : q;
endfunction

function automatic word_t model_result(input alu_op_e op, input word_t a, input word_t b);
	logic [127:0] p;
	case (op)
		op_add:   return a + b;
		op_addw:  return sext_w(a[31:0] + b[31:0]);
		op_sll:   return a << b[5:0];
		op_sllw:  return sext_w(a[31:0] << b[4:0]);
		op_sra:   return $signed(a) >>> b[5:0];
		op_sraw:  return sext_w($signed(a[31:0]) >>> b[4:0]);
		op_srl:   return a >> b[5:0];
		op_srlw:  return sext_w(a[31:0] >> b[4:0]);
		op_and:   return a & b;
		op_or:    return a | b;
		op_xor:   return a ^ b;
		op_slt:   return {63'd0, $signed(a) < $signed(b)};
		op_sltu:  return {63'd0, a < b};
		op_seq:   return {63'd0, a == b};
		op_sne:   return {63'd0, a != b};
		op_sge:   return {63'd0, $signed(a) >= $signed(b)};
		op_sgeu:  return {63'd0, a >= b};
		op_sub:   return a - b;
		op_subw:  return sext_w(a[31:0] - b[31:0]);
		op_mul:   return a * b;
		op_mulh: begin
			p = {{64{a[63]}}, a} * {{64{b[63]}}, b};   // signed 128-bit product
			return p[127:64];
		end
		op_mulhu: begin
			p = {64'd0, a} * {64'd0, b};
			return p[127:64];
		end
		op_mulw:  return sext_w(a[31:0] * b[31:0]);
		op_div:   return div_model(1'b1, 1'b0, 1'b0, a, b);
		op_divu:  return div_model(1'b0, 1'b0, 1'b0, a, b);
		op_divw:  return div_model(1'b1, 1'b1, 1'b0, a, b);
		op_divuw: return div_model(1'b0, 1'b1, 1'b0, a, b);
		op_rem:   return div_model(1'b1, 1'b0, 1'b1, a, b);
		op_remu:  return div_model(1'b0, 1'b0, 1'b1, a, b);
		op_remuw: return div_model(1'b0, 1'b1, 1'b1, a, b);
		op_remw:  return div_model(1'b1, 1'b1, 1'b1, a, b);
		default:  return '0;
	endcase
endfunction

function automatic word_t target_model(input word_t pc_val, input logic [`BIMM_W-1:0] imm);
	logic signed [`XLEN-1:0] offset;
	offset = $signed({imm, 1'b0});
	return pc_val + offset;
endfunction

function automatic mem_size_e size_model(input logic [`INS_W-1:0] ins_val, input logic store);
	if (!store)
		return size_d;
	case (ins_val[13:12])
		2'd0:    return size_b;
		2'd1:    return size_h;
		2'd2:    return size_w;
		default: return size_d;
	endcase
endfunction

`endif

// ==== dv/ex_stage_tb.sv ====
`include "ex_defs.svh"

module ex_stage_tb import ex_pkg::*; ();

	localparam int ISSUE_TIMEOUT = 400;
	localparam int DRAIN_TIMEOUT = 50;
	localparam int SB_W = 3 * `XLEN + `INS_W + `REG_IDX_W + 3;

	logic                  clk;
	logic                  reset;
	logic                  valid_in;
	word_t                 pc;
	logic [`INS_W-1:0]     ins;
	alu_op_e               alu_op;
	word_t                 src_a;
	word_t                 src_b;
	word_t                 rs2_data;
	logic [`REG_IDX_W-1:0] rd;
	logic                  reg_write;
	logic                  mem_write;
	logic                  mem_read;
	logic                  branch;
	logic [`BIMM_W-1:0]    bimm;
	logic                  next_ready;
	logic                  mem_aw_ready;
	logic                  mem_ar_ready;
	logic                  ready_out;
	logic                  valid_out;
	word_t                 out_pc;
	logic [`INS_W-1:0]     out_ins;
	word_t                 out_result;
	word_t                 out_rs2_data;
	logic [`REG_IDX_W-1:0] out_rd;
	logic                  out_reg_write;
	logic                  out_mem_write;
	logic                  out_mem_read;
	logic                  flush;
	word_t                 branch_target;
	logic                  mem_aw_valid;
	logic                  mem_ar_valid;
	word_t                 mem_addr;
	mem_size_e             mem_size;
	word_t                 mem_w_data;

	logic [31:0]           seed;
	int                    err_cnt;
	int                    xfer_cnt;
	int                    test_cnt;
	int                    base_err;
	int                    base_xfer;
	int                    offer_cnt;
	logic                  bp_on;
	logic                  hung;
	word_t                 exp_now;
	word_t                 exp_target;
	mem_size_e             exp_size;
	logic                  is_mul_op;
	logic                  is_md_op;
	logic                  gate;
	logic [SB_W-1:0]       sb_q[$];
	logic [SB_W-1:0]       sb_head;
	word_t                 exp_result;
	word_t                 exp_pc;
	logic [`INS_W-1:0]     exp_ins;
	logic [`REG_IDX_W-1:0] exp_rd;
	word_t                 exp_rs2;
	logic [2:0]            exp_ctl;

	`include "ex_tb_model.svh"

	ex_stage ex_stage_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	assign {exp_result, exp_pc, exp_ins, exp_rd, exp_rs2, exp_ctl} = sb_head;

	always_comb begin
		exp_now    = model_result(alu_op, src_a, src_b);
		exp_target = target_model(pc, bimm);
		exp_size   = size_model(ins, mem_write);
		is_mul_op  = alu_op inside {[op_mul:op_mulw]};
		is_md_op   = is_mul_op || (alu_op inside {[op_div:op_remw]});
		gate       = next_ready && (!mem_write || mem_aw_ready) && (!mem_read || mem_ar_ready);
	end

	// scoreboard, head holds what the output register should show
	always @(posedge clk) begin
		if (reset) begin
			sb_q.delete();
		end else begin
			if (valid_in && ready_out) begin
				sb_q.push_back({exp_now, pc, ins, rd, rs2_data, reg_write, mem_write, mem_read});
				xfer_cnt++;
			end
			if ((!valid_out || next_ready) && sb_q.size() > 0)
				sb_head <= sb_q.pop_front();
		end
	end

	always @(posedge clk) begin
		if (reset || !valid_in || ready_out)
			offer_cnt <= 0;
		else
			offer_cnt <= offer_cnt + 1;   // cycles the current op has waited
	end

	task automatic log_error(input string msg);
		$display("%s", msg);
		err_cnt++;
	endtask

	a_reset_idle: assert property (@(posedge clk) $fell(reset) |->
		!valid_out && !flush && !mem_aw_valid && !mem_ar_valid)
		else log_error("outputs were not idle after reset");

	a_result: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> out_result == exp_result)
		else log_error($sformatf("FAIL out_result got %h exp %h",
			$sampled(out_result), $sampled(exp_result)));

	a_fields: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> out_pc == exp_pc && out_ins == exp_ins && out_rd == exp_rd
			&& out_rs2_data == exp_rs2)
		else log_error($sformatf("FAIL out_pc/out_ins/out_rd/out_rs2_data got %h %h %h %h exp %h %h %h %h",
			$sampled(out_pc), $sampled(out_ins), $sampled(out_rd), $sampled(out_rs2_data),
			$sampled(exp_pc), $sampled(exp_ins), $sampled(exp_rd), $sampled(exp_rs2)));

	a_ctl: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> {out_reg_write, out_mem_write, out_mem_read} == exp_ctl)
		else log_error($sformatf("FAIL out_reg_write/out_mem_write/out_mem_read got %h exp %h",
			$sampled({out_reg_write, out_mem_write, out_mem_read}), $sampled(exp_ctl)));

	a_hold: assert property (@(posedge clk) disable iff (reset)
		valid_out && !next_ready |=> valid_out && $stable(out_result) && $stable(out_pc)
			&& $stable(out_ins) && $stable(out_rd))
		else log_error("registered outputs changed while next_ready was low");

	a_out_src: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> $past(valid_in && ready_out) || $past(valid_out && !next_ready))
		else log_error("valid_out rose without a transfer");

	a_ready_gate: assert property (@(posedge clk) disable iff (reset)
		ready_out |-> gate)
		else log_error("ready_out high while downstream or memory was not ready");

	a_alu_ready: assert property (@(posedge clk) disable iff (reset)
		valid_in && !is_md_op && gate |-> ready_out)
		else log_error("single-cycle op was stalled with all readies high");

	a_mul_wait: assert property (@(posedge clk) disable iff (reset)
		valid_in && is_mul_op && ready_out |-> offer_cnt >= `XLEN)
		else log_error($sformatf("multiply accepted after only %0d cycles", $sampled(offer_cnt)));

	a_mem_req: assert property (@(posedge clk) disable iff (reset)
		mem_aw_valid == (valid_in && mem_write) && mem_ar_valid == (valid_in && mem_read))
		else log_error($sformatf("FAIL mem_aw_valid/mem_ar_valid got %h %h exp %h %h",
			$sampled(mem_aw_valid), $sampled(mem_ar_valid),
			$sampled(valid_in && mem_write), $sampled(valid_in && mem_read)));

	a_mem_addr: assert property (@(posedge clk) disable iff (reset)
		valid_in && (mem_write || mem_read) |-> mem_addr == src_a + src_b
			&& mem_w_data == rs2_data)
		else log_error($sformatf("FAIL mem_addr/mem_w_data got %h %h exp %h %h",
			$sampled(mem_addr), $sampled(mem_w_data),
			$sampled(src_a + src_b), $sampled(rs2_data)));

	a_mem_size: assert property (@(posedge clk) disable iff (reset)
		valid_in |-> mem_size == exp_size)
		else log_error($sformatf("FAIL mem_size got %h exp %h",
			$sampled(mem_size), $sampled(exp_size)));

	a_flush: assert property (@(posedge clk) disable iff (reset)
		flush == (valid_in && ready_out && branch && exp_now != '0))
		else log_error($sformatf("FAIL flush got %h exp %h", $sampled(flush),
			$sampled(valid_in && ready_out && branch && exp_now != '0)));

	a_target: assert property (@(posedge clk) disable iff (reset)
		valid_in && branch |-> branch_target == exp_target)
		else log_error($sformatf("FAIL branch_target got %h exp %h",
			$sampled(branch_target), $sampled(exp_target)));

	// two LCG steps, upper halves only
	function automatic logic [31:0] next_rand();
		logic [15:0] hi;
		seed = seed * 32'd1664525 + 32'd1013904223;
		hi   = seed[31:16];
		seed = seed * 32'd1664525 + 32'd1013904223;
		return {hi, seed[31:16]};
	endfunction

	function automatic word_t pick_operand();
		logic [31:0] r;
		r = next_rand();
		case (r[31:29])
			3'd0:    return '0;
			3'd1:    return '1;
			3'd2:    return {1'b1, 63'd0};
			3'd3:    return 64'h0000_0000_8000_0000;
			default: return {next_rand(), next_rand()};
		endcase
	endfunction

	task automatic shake_readies();
		logic [31:0] r;
		r = next_rand();
		next_ready   <= r[31:30] != 2'b00;
		mem_aw_ready <= r[29] | r[28];
		mem_ar_ready <= r[27] | r[26];
	endtask

	task automatic set_backpressure(input logic on);
		bp_on = on;
		if (!on) begin
			next_ready   <= 1'b1;
			mem_aw_ready <= 1'b1;
			mem_ar_ready <= 1'b1;
		end
	endtask

	task automatic issue(input alu_op_e op, input word_t a, input word_t b, input logic st,
			input logic ld, input logic br);
		logic [31:0] r1;
		logic [31:0] r2;
		int          waited;
		logic        accepted;
		if (hung)
			return;
		r1 = next_rand();
		r2 = next_rand();
		valid_in  <= 1'b1;
		alu_op    <= op;
		src_a     <= a;
		src_b     <= b;
		rs2_data  <= {r1, r2};
		pc        <= {next_rand(), r1[31:2], 2'b00};
		ins       <= r2;
		rd        <= r1[20:16];
		reg_write <= !st && !br;
		mem_write <= st;
		mem_read  <= ld;
		branch    <= br;
		bimm      <= r1[15:4];
		waited   = 0;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			if (valid_in && ready_out) begin
				accepted = 1'b1;
			end else if (waited == ISSUE_TIMEOUT) begin
				$display("timeout: op %0d was never accepted", op);
				hung     = 1'b1;
				accepted = 1'b1;
			end
			waited++;
			if (bp_on)
				shake_readies();
		end
	endtask

	task automatic drain();
		int waited;
		valid_in <= 1'b0;
		set_backpressure(1'b0);
		waited = 0;
		while ((valid_out || waited < 2) && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (valid_out) begin
			$display("timeout: valid_out never cleared after the last transfer");
			hung = 1'b1;
		end
	endtask

	task automatic start_test();
		base_err  = err_cnt;
		base_xfer = xfer_cnt;
	endtask

	task automatic finish_test(input string name);
		test_cnt++;
		$display("test %0d %s: %0d transfers, %0d errors", test_cnt, name,
			xfer_cnt - base_xfer, err_cnt - base_err);
	endtask

	initial begin
		logic [31:0] r;
		word_t       a;
		seed         = 32'h2ee6_fc60;
		err_cnt      = 0;
		xfer_cnt     = 0;
		test_cnt     = 0;
		hung         = 1'b0;
		bp_on        = 1'b0;
		reset        = 1'b1;
		valid_in     = 1'b0;
		pc           = '0;
		ins          = '0;
		alu_op       = op_add;
		src_a        = '0;
		src_b        = '0;
		rs2_data     = '0;
		rd           = '0;
		reg_write    = 1'b0;
		mem_write    = 1'b0;
		mem_read     = 1'b0;
		branch       = 1'b0;
		bimm         = '0;
		next_ready   = 1'b1;
		mem_aw_ready = 1'b1;
		mem_ar_ready = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		start_test();
		repeat (2) @(posedge clk);
		finish_test("reset");

		start_test();
		for (int i = 0; i < 80; i++)
			issue(alu_op_e'(next_rand() % 19), pick_operand(), pick_operand(), 0, 0, 0);
		finish_test("alu");

		start_test();
		set_backpressure(1'b1);
		for (int i = 0; i < 24; i++)
			issue(alu_op_e'(op_mul + next_rand() % 4), pick_operand(), pick_operand(), 0, 0, 0);
		finish_test("mul");

		start_test();
		issue(op_div, {1'b1, 63'd0}, '1, 0, 0, 0);
		issue(op_divw, 64'h0000_0000_8000_0000, '1, 0, 0, 0);
		issue(op_rem, pick_operand(), '0, 0, 0, 0);
		issue(op_remuw, pick_operand(), 64'hffff_ffff_0000_0000, 0, 0, 0);   // low half zero
		for (int i = 0; i < 40; i++)
			issue(alu_op_e'(op_div + next_rand() % 8), pick_operand(), pick_operand(), 0, 0, 0);
		finish_test("div");

		start_test();
		set_backpressure(1'b0);
		for (int i = 0; i < 30; i++) begin
			r = next_rand();
			a = pick_operand();
			issue(alu_op_e'(op_slt + r % 6), a, r[31] ? a : pick_operand(), 0, 0, 1);
		end
		finish_test("branch");

		start_test();
		set_backpressure(1'b1);
		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			issue(op_add, {next_rand(), next_rand()}, {32'd0, r}, r[31], !r[31], 0);
		end
		finish_test("memory");

		drain();
		if (sb_q.size() != 0)
			log_error("scoreboard still holds entries at the end");
		$display("%0d tests, %0d transfers, %0d errors", test_cnt, xfer_cnt, err_cnt);
		if (err_cnt == 0 && !hung)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+design
+incdir+dv
design/ex_pkg.sv
design/int_alu.sv
design/mul_unit.sv
design/div_unit.sv
design/ex_stage.sv
dv/ex_stage_tb.sv
